// ==== filelist.f ====
+incdir+hdl
hdl/lcd_pkg.sv
hdl/glyph_decoder.sv
hdl/tile_ingress.sv
hdl/lcd_tile_writer.sv
hdl/lcd_bus_driver.sv
hdl/lcd_tile_display.sv
tb/lcd_panel_model.sv
tb/lcd_tile_display_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= lcd_tile_display_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -Wno-fatal
PASS_TEXT ?= ** PASS **

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/lcd_tile_display_tb.sv ====
`include "glyph_table.svh"

module lcd_tile_display_tb import lcd_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 4;
	localparam int INIT_XFERS = 4;
	localparam int XFERS_PER_TILE = 36;
	localparam int MAX_TILES = 40;
	localparam int WATCHDOG_TIME = MAX_TILES * XFERS_PER_TILE * 8 * 2 * CLK_PERIOD;
	localparam int WAIT_CYCLES = (TILE_CREDITS + 1) * XFERS_PER_TILE * 8 * 2;

	logic             clk;
	logic             reset;
	logic             tile_valid;
	logic [7:0]       tile_code;
	logic [ROW_W-1:0] tile_row;
	logic [COL_W-1:0] tile_col;
	logic             credit_return;
	logic [1:0]       lcd_cs;
	logic             lcd_rs;
	logic             lcd_rw;
	logic             lcd_en;
	logic [7:0]       lcd_data;

	int credits;
	int total_returns;
	int tiles_sent;
	int check_count;
	int error_count;
	logic [7:0] exp_frame [2][8][64]; // expected panel image.

	lcd_tile_display u_lcd_tile_display (
		.clk(clk),
		.reset(reset),
		.tile_valid(tile_valid),
		.tile_code(tile_code),
		.tile_row(tile_row),
		.tile_col(tile_col),
		.credit_return(credit_return),
		.lcd_cs(lcd_cs),
		.lcd_rs(lcd_rs),
		.lcd_rw(lcd_rw),
		.lcd_en(lcd_en),
		.lcd_data(lcd_data)
	);

	lcd_panel_model u_panel (
		.clk(clk),
		.lcd_cs(lcd_cs),
		.lcd_rs(lcd_rs),
		.lcd_rw(lcd_rw),
		.lcd_en(lcd_en),
		.lcd_data(lcd_data)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// host side credit counter.
	always @(posedge clk) begin
		if (!reset && credit_return) begin
			credits = credits + 1;
			total_returns = total_returns + 1;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	function automatic logic [255:0] glyph_bits(input logic [7:0] code);
		case (code)
			8'h00: return `GLYPH_BMP_0;
			8'h01: return `GLYPH_BMP_1;
			8'h02: return `GLYPH_BMP_2;
			8'h03: return `GLYPH_BMP_3;
			8'h04: return `GLYPH_BMP_4;
			8'h05: return `GLYPH_BMP_5;
			8'h06: return `GLYPH_BMP_6;
			8'h07: return `GLYPH_BMP_7;
			8'h08: return `GLYPH_BMP_8;
			8'h09: return `GLYPH_BMP_9;
			8'h0A: return `GLYPH_BMP_A;
			8'h0B: return `GLYPH_BMP_B;
			8'h0C: return `GLYPH_BMP_C;
			8'h0D: return `GLYPH_BMP_D;
			8'h0E: return `GLYPH_BMP_E;
			8'h0F: return `GLYPH_BMP_F;
			8'h80: return `GLYPH_BMP_SMILE;
			default: return `GLYPH_BMP_BLANK;
		endcase
	endfunction

	function automatic logic [7:0] listed_code(input int pick);
		if (pick < 16)
			return 8'(pick);
		else if (pick == 16)
			return 8'h80; // smile.
		else
			return 8'hFF;
	endfunction

	// screen row y sits in page y / 8 at bit y % 8.
	task automatic paint_tile(input logic [7:0] code, input int row, input int col);
		logic [255:0] bits;
		logic [15:0] row_bits;
		int chip;
		int x0;
		int y;
		bits = glyph_bits(code);
		chip = col / (CHIP_COLS / TILE_PIX);
		x0 = (col % (CHIP_COLS / TILE_PIX)) * TILE_PIX;
		for (int r = 0; r < TILE_PIX; r++) begin
			row_bits = bits[255 - r * TILE_PIX -: TILE_PIX];
			y = row * TILE_PIX + r;
			for (int c = 0; c < TILE_PIX; c++)
				exp_frame[chip][y / 8][x0 + c][y % 8] = row_bits[TILE_PIX - 1 - c];
		end
	endtask

	// enters and leaves on a falling edge.
	task automatic send_tile(input logic [7:0] code, input int row, input int col);
		while (credits == 0)
			@(negedge clk);
		tile_valid = 1'b1;
		tile_code = code;
		tile_row = ROW_W'(row);
		tile_col = COL_W'(col);
		credits = credits - 1;
		tiles_sent = tiles_sent + 1;
		paint_tile(code, row, col);
		@(negedge clk);
		tile_valid = 1'b0;
	endtask

	task automatic wait_for_writes(input string name, input int target);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (u_panel.write_count < target && cycles < WAIT_CYCLES);
		if (u_panel.write_count < target) begin
			error_count++;
			$display("%s: timed out, the panel saw %0d of %0d bus writes", name,
				u_panel.write_count, target);
		end
		@(negedge clk);
	endtask

	task automatic compare_frame(input string name);
		for (int c = 0; c < 2; c++)
			for (int p = 0; p < 8; p++)
				for (int x = 0; x < CHIP_COLS; x++)
					check_value($sformatf("%s chip %0d page %0d col %0d", name, c, p, x),
						32'(exp_frame[c][p][x]), 32'(u_panel.frame[c][p][x]));
	endtask

	task automatic check_init_sequence();
		check_value("init en low", 32'd0, 32'(lcd_en));
		check_value("init cs low", 32'd0, 32'(lcd_cs));
		check_value("init rw low", 32'd0, 32'(lcd_rw));
		check_value("init credit_return low", 32'd0, 32'(credit_return));
		wait_for_writes("init", INIT_XFERS);
		for (int i = 0; i < INIT_XFERS; i++) begin
			check_value($sformatf("init write %0d cs", i), (i < 2) ? 32'h1 : 32'h2,
				32'(u_panel.log_cs[i]));
			check_value($sformatf("init write %0d rs", i), 32'd0, 32'(u_panel.log_rs[i]));
			check_value($sformatf("init write %0d data", i), (i % 2 == 1) ? 32'hC0 : 32'h3F,
				32'(u_panel.log_data[i]));
		end
		for (int c = 0; c < 2; c++) begin
			check_value($sformatf("init chip %0d display on", c), 32'd1,
				32'(u_panel.display_on[c]));
			check_value($sformatf("init chip %0d start line", c), 32'd0,
				32'(u_panel.start_line[c]));
		end
	endtask

	task automatic draw_digit_tile();
		send_tile(8'h07, 1, 2);
		wait_for_writes("digit_tile", INIT_XFERS + XFERS_PER_TILE * tiles_sent);
		compare_frame("digit_tile");
	endtask

	task automatic draw_smile_tile();
		send_tile(8'h80, 0, 6);
		wait_for_writes("smile_tile", INIT_XFERS + XFERS_PER_TILE * tiles_sent);
		compare_frame("smile_tile");
	endtask

	task automatic clear_with_unlisted_code();
		send_tile(8'h42, 0, 6); // not in the glyph set.
		wait_for_writes("unlisted_code", INIT_XFERS + XFERS_PER_TILE * tiles_sent);
		compare_frame("unlisted_code");
	endtask

	task automatic run_credit_flow();
		int returns_before;
		int cycles;
		check_value("credit_flow credits held", 32'(TILE_CREDITS), 32'(credits));
		returns_before = total_returns;
		for (int i = 0; i < TILE_CREDITS; i++)
			send_tile(8'(8'h0A + i), 3, i);
		cycles = 0;
		while (total_returns - returns_before < TILE_CREDITS && cycles < WAIT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		check_value("credit_flow returns after burst", 32'(TILE_CREDITS),
			32'(total_returns - returns_before));
		for (int r = 0; r < TILE_ROWS; r++)
			for (int c = 0; c < TILE_COLS; c++)
				send_tile(listed_code(int'($urandom % 18)), r, c);
		wait_for_writes("credit_flow", INIT_XFERS + XFERS_PER_TILE * tiles_sent);
		compare_frame("credit_flow");
		check_value("credit_flow total returns", 32'(tiles_sent), 32'(total_returns));
		check_value("credit_flow credits back", 32'(TILE_CREDITS), 32'(credits));
	endtask

	initial begin
		void'($urandom(68));
		reset = 1'b1;
		tile_valid = 1'b0;
		tile_code = 8'h00;
		tile_row = '0;
		tile_col = '0;
		credits = TILE_CREDITS;
		total_returns = 0;
		tiles_sent = 0;
		check_count = 0;
		error_count = 0;
		for (int c = 0; c < 2; c++)
			for (int p = 0; p < 8; p++)
				for (int x = 0; x < 64; x++)
					exp_frame[c][p][x] = 8'h00;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_init_sequence();
		draw_digit_tile();
		draw_smile_tile();
		clear_with_unlisted_code();
		run_credit_flow();
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("watchdog expired after %0d time units, the run did not finish",
			WATCHDOG_TIME);
		$display("%0d checks, %0d errors", check_count, error_count);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== tb/lcd_panel_model.sv ====
module lcd_panel_model (
	input logic       clk,
	input logic [1:0] lcd_cs,
	input logic       lcd_rs,
	input logic       lcd_rw,
	input logic       lcd_en,
	input logic [7:0] lcd_data
);

	localparam int LOG_DEPTH = 8;

	logic [7:0] frame [2][8][64];
	logic [2:0] page_reg [2];
	logic [5:0] col_reg [2];
	logic       display_on [2];
	logic [5:0] start_line [2];
	logic [1:0] log_cs [LOG_DEPTH]; // first few bus writes, in order.
	logic       log_rs [LOG_DEPTH];
	logic [7:0] log_data [LOG_DEPTH];
	logic       en_q;
	int         write_count;

	initial begin
		en_q = 1'b0;
		write_count = 0;
		for (int c = 0; c < 2; c++) begin
			page_reg[c] = 3'd0;
			col_reg[c] = 6'd0;
			display_on[c] = 1'b0;
			start_line[c] = 6'd0;
			for (int p = 0; p < 8; p++)
				for (int x = 0; x < 64; x++)
					frame[c][p][x] = 8'h00;
		end
	end

	task automatic apply_write(input int c);
		if (lcd_rs) begin
			frame[c][page_reg[c]][col_reg[c]] = lcd_data;
			col_reg[c] = col_reg[c] + 6'd1; // column auto-increment.
		end else if (lcd_data[7:6] == 2'b01) begin
			col_reg[c] = lcd_data[5:0];
		end else if (lcd_data[7:3] == 5'b10111) begin
			page_reg[c] = lcd_data[2:0];
		end else if (lcd_data[7:6] == 2'b11) begin
			start_line[c] = lcd_data[5:0];
		end else if (lcd_data[7:1] == 7'b0011111) begin
			display_on[c] = lcd_data[0];
		end
	endtask

	// sampled mid-cycle, a falling en shows as en_q high with en low.
	always @(negedge clk) begin
		if (en_q && !lcd_en && !lcd_rw) begin
			if (write_count < LOG_DEPTH) begin
				log_cs[write_count] = lcd_cs;
				log_rs[write_count] = lcd_rs;
				log_data[write_count] = lcd_data;
			end
			write_count = write_count + 1;
			for (int c = 0; c < 2; c++)
				if (lcd_cs[c])
					apply_write(c);
		end
		en_q = lcd_en;
	end

endmodule

// ==== hdl/lcd_tile_display.sv ====
module lcd_tile_display import lcd_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             tile_valid,
	input  logic [7:0]       tile_code,
	input  logic [ROW_W-1:0] tile_row,
	input  logic [COL_W-1:0] tile_col,
	output logic             credit_return,
	output logic [1:0]       lcd_cs,
	output logic             lcd_rs,
	output logic             lcd_rw,
	output logic             lcd_en,
	output logic [7:0]       lcd_data
);

	logic             q_valid;
	logic [7:0]       q_code;
	logic [ROW_W-1:0] q_row;
	logic [COL_W-1:0] q_col;
	logic             q_pop;
	logic [7:0]       glyph_code;
	logic [255:0]     bitmap;
	logic             req;
	lcd_op_t          req_op;
	logic [7:0]       req_data;
	logic             req_chip;
	logic             ready;

	tile_ingress u_ingress (
		.clk(clk),
		.reset(reset),
		.tile_valid(tile_valid),
		.tile_code(tile_code),
		.tile_row(tile_row),
		.tile_col(tile_col),
		.q_pop(q_pop),
		.q_valid(q_valid),
		.q_code(q_code),
		.q_row(q_row),
		.q_col(q_col),
		.credit_return(credit_return)
	);

	lcd_tile_writer u_writer (
		.clk(clk),
		.reset(reset),
		.q_valid(q_valid),
		.q_code(q_code),
		.q_row(q_row),
		.q_col(q_col),
		.bitmap(bitmap),
		.ready(ready),
		.q_pop(q_pop),
		.glyph_code(glyph_code),
		.req(req),
		.req_op(req_op),
		.req_data(req_data),
		.req_chip(req_chip)
	);

	glyph_decoder u_decoder (
		.glyph_code(glyph_code),
		.bitmap(bitmap)
	);

	lcd_bus_driver u_bus (
		.clk(clk),
		.reset(reset),
		.req(req),
		.req_op(req_op),
		.req_data(req_data),
		.req_chip(req_chip),
		.ready(ready),
		.lcd_cs(lcd_cs),
		.lcd_rs(lcd_rs),
		.lcd_rw(lcd_rw),
		.lcd_en(lcd_en),
		.lcd_data(lcd_data)
	);

endmodule

// ==== hdl/lcd_bus_driver.sv ====
module lcd_bus_driver import lcd_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       req,
	input  lcd_op_t    req_op,
	input  logic [7:0] req_data,
	input  logic       req_chip,
	output logic       ready,
	output logic [1:0] lcd_cs,
	output logic       lcd_rs,
	output logic       lcd_rw,
	output logic       lcd_en,
	output logic [7:0] lcd_data
);

	logic busy;
	logic [XFER_W-1:0] phase;

	assign ready = !busy;
	assign lcd_rw = 1'b0; // write only.

	// payload held for the whole transaction.
	always_ff @(posedge clk) begin
		if (req && ready) begin
			lcd_rs <= req_op;
			lcd_data <= req_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			phase <= '0;
			lcd_en <= 1'b0;
			lcd_cs <= 2'b00;
		end else if (!busy) begin
			if (req) begin
				busy <= 1'b1;
				phase <= '0;
				lcd_cs <= req_chip ? 2'b10 : 2'b01;
			end
		end else begin
			phase <= phase + 1'b1;
			if (phase == XFER_W'(T_SETUP - 1))
				lcd_en <= 1'b1; // setup done.
			if (phase == XFER_W'(T_SETUP + T_PULSE - 1))
				lcd_en <= 1'b0; // panel latches here.
			if (phase == XFER_W'(XFER_CYCLES - 1)) begin
				busy <= 1'b0;
				lcd_cs <= 2'b00;
			end
		end
	end

endmodule

// ==== hdl/lcd_tile_writer.sv ====
module lcd_tile_writer import lcd_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             q_valid,
	input  logic [7:0]       q_code,
	input  logic [ROW_W-1:0] q_row,
	input  logic [COL_W-1:0] q_col,
	input  logic [255:0]     bitmap,
	input  logic             ready,
	output logic             q_pop,
	output logic [7:0]       glyph_code,
	output logic             req,
	output lcd_op_t          req_op,
	output logic [7:0]       req_data,
	output logic             req_chip
);

	writer_state_t state;
	logic [1:0] init_step;
	logic page_half; // 0 for the upper page of the tile.
	logic [PIX_W-1:0] byte_col;
	logic [7:0] code_r;
	logic [ROW_W-1:0] tile_row_r;
	logic [CHIP_COL_W-1:0] col_base;
	logic chip_r;
	logic [7:0] data_byte;
	logic accept;

	assign accept = req && ready;
	assign q_pop = (state == IDLE) && q_valid;
	assign glyph_code = code_r;

	// one column of 8 pixels, top pixel in bit 0.
	always_comb begin
		for (int k = 0; k < 8; k++) begin
			data_byte[k] = bitmap[255 - ((page_half * 8 + k) * TILE_PIX + byte_col)];
		end
	end

	always_comb begin
		req = 1'b0;
		req_op = OP_CMD;
		req_data = 8'h00;
		req_chip = chip_r;
		case (state)
			INIT: begin
				req = 1'b1;
				req_data = init_step[0] ? CMD_START_LINE : CMD_DISPLAY_ON;
				req_chip = init_step[1];
			end
			SET_PAGE: begin
				req = 1'b1;
				req_data = CMD_SET_PAGE | 8'({tile_row_r, page_half});
			end
			SET_COL: begin
				req = 1'b1;
				req_data = CMD_SET_COL | 8'(col_base);
			end
			DATA: begin
				req = 1'b1;
				req_op = OP_DATA;
				req_data = data_byte;
			end
			default: req = 1'b0;
		endcase
	end

	// tile fields captured at the pop.
	always_ff @(posedge clk) begin
		if (q_pop) begin
			code_r <= q_code;
			tile_row_r <= q_row;
			col_base <= CHIP_COL_W'((q_col % TILES_PER_CHIP) * TILE_PIX);
			chip_r <= (q_col >= COL_W'(TILES_PER_CHIP));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= INIT;
			init_step <= 2'd0;
			page_half <= 1'b0;
			byte_col <= '0;
		end else begin
			case (state)
				INIT: begin
					if (accept) begin
						init_step <= init_step + 2'd1;
						if (init_step == 2'd3)
							state <= IDLE; // both chips are on.
					end
				end
				IDLE: begin
					if (q_valid) begin
						page_half <= 1'b0;
						state <= SET_PAGE;
					end
				end
				SET_PAGE: begin
					if (accept)
						state <= SET_COL;
				end
				SET_COL: begin
					if (accept) begin
						byte_col <= '0;
						state <= DATA;
					end
				end
				DATA: begin
					if (accept) begin
						byte_col <= byte_col + 1'b1;
						if (byte_col == PIX_W'(TILE_PIX - 1))
							state <= NEXT_PAGE;
					end
				end
				NEXT_PAGE: begin
					page_half <= 1'b1;
					state <= page_half ? IDLE : SET_PAGE;
				end
				default: state <= INIT;
			endcase
		end
	end

endmodule

// ==== hdl/tile_ingress.sv ====
module tile_ingress import lcd_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             tile_valid,
	input  logic [7:0]       tile_code,
	input  logic [ROW_W-1:0] tile_row,
	input  logic [COL_W-1:0] tile_col,
	input  logic             q_pop,
	output logic             q_valid,
	output logic [7:0]       q_code,
	output logic [ROW_W-1:0] q_row,
	output logic [COL_W-1:0] q_col,
	output logic             credit_return
);

	logic [7:0]       code_mem [TILE_CREDITS];
	logic [ROW_W-1:0] row_mem [TILE_CREDITS];
	logic [COL_W-1:0] col_mem [TILE_CREDITS];
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QPTR_W:0]   count;
	logic do_pop;

	assign q_valid = (count != '0);
	assign do_pop = q_pop && q_valid;
	assign credit_return = do_pop; // one credit per tile taken.

	assign q_code = code_mem[rd_ptr];
	assign q_row = row_mem[rd_ptr];
	assign q_col = col_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (tile_valid) begin
			code_mem[wr_ptr] <= tile_code;
			row_mem[wr_ptr] <= tile_row;
			col_mem[wr_ptr] <= tile_col;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (tile_valid)
				wr_ptr <= (wr_ptr == QPTR_W'(TILE_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == QPTR_W'(TILE_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			if (tile_valid && !do_pop)
				count <= count + 1'b1;
			else if (!tile_valid && do_pop)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== hdl/glyph_decoder.sv ====
`include "glyph_table.svh"

module glyph_decoder import lcd_pkg::*; (
	input  logic [7:0]   glyph_code,
	output logic [255:0] bitmap
);

	always_comb begin
		case (glyph_code)
			GLYPH_0: bitmap = `GLYPH_BMP_0;
			GLYPH_1: bitmap = `GLYPH_BMP_1;
			GLYPH_2: bitmap = `GLYPH_BMP_2;
			GLYPH_3: bitmap = `GLYPH_BMP_3;
			GLYPH_4: bitmap = `GLYPH_BMP_4;
			GLYPH_5: bitmap = `GLYPH_BMP_5;
			GLYPH_6: bitmap = `GLYPH_BMP_6;
			GLYPH_7: bitmap = `GLYPH_BMP_7;
			GLYPH_8: bitmap = `GLYPH_BMP_8;
			GLYPH_9: bitmap = `GLYPH_BMP_9;
			GLYPH_A: bitmap = `GLYPH_BMP_A;
			GLYPH_B: bitmap = `GLYPH_BMP_B;
			GLYPH_C: bitmap = `GLYPH_BMP_C;
			GLYPH_D: bitmap = `GLYPH_BMP_D;
			GLYPH_E: bitmap = `GLYPH_BMP_E;
			GLYPH_F: bitmap = `GLYPH_BMP_F;
			GLYPH_SMILE: bitmap = `GLYPH_BMP_SMILE;
			GLYPH_BLANK: bitmap = `GLYPH_BMP_BLANK;
			default: bitmap = `GLYPH_BMP_BLANK; // unknown codes clear the tile.
		endcase
	end

endmodule

// ==== hdl/lcd_pkg.sv ====
package lcd_pkg;

	// screen geometry.
	localparam int TILE_COLS = 8;
	localparam int TILE_ROWS = 4;
	localparam int TILE_PIX = 16;
	localparam int CHIP_COLS = 64;
	localparam int TILE_CREDITS = 4; // also the queue depth.

	localparam int TILES_PER_CHIP = CHIP_COLS / TILE_PIX;
	localparam int ROW_W = $clog2(TILE_ROWS);
	localparam int COL_W = $clog2(TILE_COLS);
	localparam int PIX_W = $clog2(TILE_PIX);
	localparam int CHIP_COL_W = $clog2(CHIP_COLS);
	localparam int QPTR_W = $clog2(TILE_CREDITS);

	// bus strobe timing in clock cycles.
	localparam int T_SETUP = 2;
	localparam int T_PULSE = 4;
	localparam int T_HOLD = 2;
	localparam int XFER_CYCLES = T_SETUP + T_PULSE + T_HOLD;
	localparam int XFER_W = $clog2(XFER_CYCLES);

	localparam logic [7:0] CMD_DISPLAY_ON = 8'h3F;
	localparam logic [7:0] CMD_START_LINE = 8'hC0;
	localparam logic [7:0] CMD_SET_PAGE = 8'hB8; // page in bits 2:0.
	localparam logic [7:0] CMD_SET_COL = 8'h40; // column in bits 5:0.

	typedef enum logic [7:0] {
		GLYPH_0 = 8'h00, GLYPH_1 = 8'h01, GLYPH_2 = 8'h02, GLYPH_3 = 8'h03,
		GLYPH_4 = 8'h04, GLYPH_5 = 8'h05, GLYPH_6 = 8'h06, GLYPH_7 = 8'h07,
		GLYPH_8 = 8'h08, GLYPH_9 = 8'h09, GLYPH_A = 8'h0A, GLYPH_B = 8'h0B,
		GLYPH_C = 8'h0C, GLYPH_D = 8'h0D, GLYPH_E = 8'h0E, GLYPH_F = 8'h0F,
		GLYPH_SMILE = 8'h80,
		GLYPH_BLANK = 8'hFF
	} glyph_code_t;

	typedef enum logic {
		OP_CMD = 1'b0,
		OP_DATA = 1'b1
	} lcd_op_t;

	typedef enum logic [2:0] {
		INIT, IDLE, SET_PAGE, SET_COL, DATA, NEXT_PAGE
	} writer_state_t;

endpackage

// ==== hdl/glyph_table.svh ====
`ifndef GLYPH_TABLE_SVH
`define GLYPH_TABLE_SVH

// 16x16 bitmaps, four rows per 64-bit group, top row first.

`define GLYPH_BMP_0 {64'h0000_0000_1FF8_1818, 64'h1818_1818_1818_1818, \
	64'h1818_1818_1818_1818, 64'h1818_1FF8_0000_0000}

`define GLYPH_BMP_1 {64'h0000_0000_0180_0380, 64'h0180_0180_0180_0180, \
	64'h0180_0180_0180_0180, 64'h0180_07E0_0000_0000}

`define GLYPH_BMP_2 {64'h0000_0000_1FF8_0018, 64'h0018_0018_0018_0018, \
	64'h1FF8_1800_1800_1800, 64'h1800_1FF8_0000_0000}

`define GLYPH_BMP_3 {64'h0000_0000_1FF8_0018, 64'h0018_0018_0018_0018, \
	64'h1FF8_0018_0018_0018, 64'h0018_1FF8_0000_0000}

`define GLYPH_BMP_4 {64'h0000_0000_1818_1818, 64'h1818_1818_1818_1818, \
	64'h1FF8_0018_0018_0018, 64'h0018_0018_0000_0000}

`define GLYPH_BMP_5 {64'h0000_0000_1FF8_1800, 64'h1800_1800_1800_1800, \
	64'h1FF8_0018_0018_0018, 64'h0018_1FF8_0000_0000}

`define GLYPH_BMP_6 {64'h0000_0000_1FF8_1800, 64'h1800_1800_1800_1800, \
	64'h1FF8_1818_1818_1818, 64'h1818_1FF8_0000_0000}

`define GLYPH_BMP_7 {64'h0000_0000_1FF8_0018, 64'h0018_0018_0018_0018, \
	64'h0018_0018_0018_0018, 64'h0018_0018_0000_0000}

`define GLYPH_BMP_8 {64'h0000_0000_1FF8_1818, 64'h1818_1818_1818_1818, \
	64'h1FF8_1818_1818_1818, 64'h1818_1FF8_0000_0000}

`define GLYPH_BMP_9 {64'h0000_0000_1FF8_1818, 64'h1818_1818_1818_1818, \
	64'h1FF8_0018_0018_0018, 64'h0018_1FF8_0000_0000}

`define GLYPH_BMP_A {64'h0000_0000_1FF8_1818, 64'h1818_1818_1818_1818, \
	64'h1FF8_1818_1818_1818, 64'h1818_1818_0000_0000}

`define GLYPH_BMP_B {64'h0000_0000_1FF0_1818, 64'h1818_1818_1818_1818, \
	64'h1FF0_1818_1818_1818, 64'h1818_1FF0_0000_0000}

`define GLYPH_BMP_C {64'h0000_0000_1FF8_1800, 64'h1800_1800_1800_1800, \
	64'h1800_1800_1800_1800, 64'h1800_1FF8_0000_0000}

`define GLYPH_BMP_D {64'h0000_0000_1FF0_1818, 64'h1818_1818_1818_1818, \
	64'h1818_1818_1818_1818, 64'h1818_1FF0_0000_0000}

`define GLYPH_BMP_E {64'h0000_0000_1FF8_1800, 64'h1800_1800_1800_1800, \
	64'h1FF8_1800_1800_1800, 64'h1800_1FF8_0000_0000}

`define GLYPH_BMP_F {64'h0000_0000_1FF8_1800, 64'h1800_1800_1800_1800, \
	64'h1FF8_1800_1800_1800, 64'h1800_1800_0000_0000}

// round face with two eyes and a mouth.
`define GLYPH_BMP_SMILE {64'h0000_07E0_1818_2004, 64'h4C32_4C32_8001_8001, \
	64'h8001_9009_8811_47E2, 64'h2004_1818_07E0_0000}

`define GLYPH_BMP_BLANK 256'h0

`endif
